// File: filelist.f
common/core_pkg.sv
decode/reg_file.sv
decode/decode_stage.sv
design/fetch_unit.sv
design/exec_stage.sv
design/writeback_stage.sv
design/core_top.sv
verif/tb_clock.sv
verif/tb_top.sv

// File: run.sh
#!/bin/sh
# builds the core testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
PASS_TEXT="Done: no errors"

verilator --binary --timing --assert -f filelist.f --top-module tb_top \
  -Mdir "$BUILD_DIR" -o vtb_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/vtb_top" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "$PASS_TEXT" "$LOG_FILE"; then
  echo "run passed"
  exit 0
fi
echo "run failed, see $LOG_FILE"
exit 1

// File: verif/tb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_top
  import core_pkg::*;
();

  localparam int PROG_LEN       = 64;
  localparam int RESET_CYCLES   = 10;
  localparam int PIPE_LATENCY   = 3;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * PROG_LEN + 20;

  // instruction kinds of the random program
  localparam int K_ADD  = 0;
  localparam int K_SUB  = 1;
  localparam int K_AND  = 2;
  localparam int K_OR   = 3;
  localparam int K_XOR  = 4;
  localparam int K_ADDI = 5;
  localparam int K_ANDI = 6;
  localparam int K_ORI  = 7;
  localparam int K_XORI = 8;
  localparam int K_LUI  = 9;
  localparam int K_BEQ  = 10;
  localparam int K_BNE  = 11;

  logic    clk;
  logic    rst_n;
  xlen_t   imem_addr;
  instr_u  imem_data;
  commit_t commit;
  xlen_t   reg_a0;

  // program fields and encoded words
  int          kind_arr  [PROG_LEN];
  reg_idx_t    rd_arr    [PROG_LEN];
  reg_idx_t    rs1_arr   [PROG_LEN];
  reg_idx_t    rs2_arr   [PROG_LEN];
  logic [19:0] imm_arr   [PROG_LEN];
  logic [31:0] prog_mem  [PROG_LEN];
  int          fetch_cycle [PROG_LEN];

  // reference model state
  xlen_t model_regs [32];
  xlen_t model_pc;
  logic  model_done;
  logic  last_taken;
  xlen_t last_target;

  int cycle_cnt;
  int err_reset;
  int err_flow;
  int err_data;
  int err_timing;
  int err_a0;
  int err_timeout;

  tb_clock u_tb_clock (
    .clk_o (clk)
  );

  core_top u_core_top (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .commit_o    (commit),
    .reg_a0_o    (reg_a0)
  );

  // RV encoding straight from the field arrays
  function automatic logic [31:0] encode_instr(input int idx);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [12:0] off;
    logic [31:0] word;
    off = imm_arr[idx][12:0];
    f7  = (kind_arr[idx] == K_SUB) ? 7'b0100000 : 7'b0000000;
    case (kind_arr[idx])
      K_XOR, K_XORI: f3 = 3'b100;
      K_OR, K_ORI:   f3 = 3'b110;
      K_AND, K_ANDI: f3 = 3'b111;
      K_BNE:         f3 = 3'b001;
      default:       f3 = 3'b000;
    endcase
    if (kind_arr[idx] <= K_XOR) begin
      word = {f7, rs2_arr[idx], rs1_arr[idx], f3, rd_arr[idx], 7'b0110011};
    end else if (kind_arr[idx] <= K_XORI) begin
      word = {imm_arr[idx][11:0], rs1_arr[idx], f3, rd_arr[idx], 7'b0010011};
    end else if (kind_arr[idx] == K_LUI) begin
      word = {imm_arr[idx], rd_arr[idx], 7'b0110111};
    end else begin
      // B-type offset bits scattered around rs1/rs2
      word = {off[12], off[10:5], rs2_arr[idx], rs1_arr[idx], f3,
              off[4:1], off[11], 7'b1100011};
    end
    return word;
  endfunction

  // x0..x7 plus a0, so a0 sees writes too
  function automatic reg_idx_t pick_reg();
    int unsigned r;
    r = $urandom % 9;
    return (r == 8) ? reg_idx_t'(10) : reg_idx_t'(r);
  endfunction

  // few registers, so dependencies pile up
  task automatic build_program();
    for (int i = 0; i < PROG_LEN; i++) begin
      kind_arr[i] = int'($urandom % 12);
      rd_arr[i]   = pick_reg();
      rs1_arr[i]  = pick_reg();
      rs2_arr[i]  = pick_reg();
      imm_arr[i]  = 20'($urandom);
      // forward branches only
      if (kind_arr[i] == K_BEQ || kind_arr[i] == K_BNE) begin
        imm_arr[i] = ($urandom % 2 == 0) ? 20'd8 : 20'd12;
      end
      prog_mem[i]    = encode_instr(i);
      fetch_cycle[i] = -1;
    end
  endtask

  // ISA result for one instruction on current model registers
  function automatic xlen_t model_result(input int idx);
    xlen_t a;
    xlen_t b;
    xlen_t imm;
    xlen_t res;
    a   = model_regs[rs1_arr[idx]];
    b   = model_regs[rs2_arr[idx]];
    imm = {{(XLEN-12){imm_arr[idx][11]}}, imm_arr[idx][11:0]};
    case (kind_arr[idx])
      K_ADD:   res = a + b;
      K_SUB:   res = a - b;
      K_AND:   res = a & b;
      K_OR:    res = a | b;
      K_XOR:   res = a ^ b;
      K_ADDI:  res = a + imm;
      K_ANDI:  res = a & imm;
      K_ORI:   res = a | imm;
      K_XORI:  res = a ^ imm;
      K_LUI:   res = {{(XLEN-32){imm_arr[idx][19]}}, imm_arr[idx], 12'b0};
      default: res = '0;
    endcase
    return res;
  endfunction

  function automatic logic model_taken(input int idx);
    logic eq;
    eq = (model_regs[rs1_arr[idx]] == model_regs[rs2_arr[idx]]);
    return (kind_arr[idx] == K_BEQ && eq) || (kind_arr[idx] == K_BNE && !eq);
  endfunction

  // beyond the program imem reads as zero, decoded as a bubble
  function automatic logic [31:0] fetch_word(input xlen_t addr);
    logic [31:0] word;
    word = '0;
    if (addr < xlen_t'(PROG_LEN * 4)) begin
      word = prog_mem[int'(addr >> 2)];
    end
    return word;
  endfunction

  task automatic check_reset();
    // reset cycles plus the first one after
    if (cycle_cnt <= RESET_CYCLES + 1) begin
      assert (!commit.valid) else begin
        err_reset++;
        $display("commit valid seen during reset in cycle %0d", cycle_cnt);
      end
    end
    if (cycle_cnt == RESET_CYCLES) begin
      assert (imem_addr == RESET_PC) else begin
        err_reset++;
        $display("error imem_addr_o got %h expected %h", imem_addr, RESET_PC);
      end
    end
  endtask

  task automatic check_commit();
    int    idx;
    xlen_t exp_data;
    logic  exp_wb_en;
    idx       = int'(model_pc >> 2);
    exp_data  = model_result(idx);
    exp_wb_en = (kind_arr[idx] != K_BEQ) && (kind_arr[idx] != K_BNE);
    assert (commit.pc == model_pc) else begin
      err_flow++;
      $display("error commit_o.pc got %h expected %h", commit.pc, model_pc);
    end
    assert (commit.instr == prog_mem[idx]) else begin
      err_flow++;
      $display("error commit_o.instr got %h expected %h", commit.instr, prog_mem[idx]);
    end
    // first commit after a taken branch lands on its target
    if (last_taken) begin
      assert (commit.pc == last_target) else begin
        err_flow++;
        $display("error commit_o.pc after branch got %h expected %h",
                 commit.pc, last_target);
      end
    end
    assert (commit.wb_en == exp_wb_en) else begin
      err_data++;
      $display("error commit_o.wb_en got %h expected %h", commit.wb_en, exp_wb_en);
    end
    if (exp_wb_en) begin
      assert (commit.rd_idx == rd_arr[idx]) else begin
        err_data++;
        $display("error commit_o.rd_idx got %h expected %h", commit.rd_idx, rd_arr[idx]);
      end
    end
    assert (cycle_cnt - fetch_cycle[idx] == PIPE_LATENCY) else begin
      err_timing++;
      $display("commit of pc %h came %0d cycles after its fetch instead of %0d",
               model_pc, cycle_cnt - fetch_cycle[idx], PIPE_LATENCY);
    end
    if (exp_wb_en && rd_arr[idx] != '0) begin
      assert (commit.data == exp_data) else begin
        err_data++;
        $display("error commit_o.data got %h expected %h", commit.data, exp_data);
      end
      model_regs[rd_arr[idx]] = exp_data;
    end
    // advance the model pc
    last_taken = 1'b0;
    if (!exp_wb_en && model_taken(idx)) begin
      last_taken  = 1'b1;
      last_target = model_pc + xlen_t'(imm_arr[idx][12:0]);
      model_pc    = last_target;
    end else begin
      model_pc = model_pc + xlen_t'(4);
    end
    if (model_pc >= xlen_t'(PROG_LEN * 4)) begin
      model_done = 1'b1;
    end
  endtask

  task automatic check_a0();
    assert (reg_a0 == model_regs[10]) else begin
      err_a0++;
      $display("error reg_a0_o got %h expected %h", reg_a0, model_regs[10]);
    end
  endtask

  task automatic drive_imem();
    int idx;
    idx = int'(imem_addr >> 2);
    // remember when each program address was on the bus
    if (rst_n && imem_addr < xlen_t'(PROG_LEN * 4)) begin
      fetch_cycle[idx] = cycle_cnt;
    end
    imem_data = fetch_word(imem_addr);
  endtask

  initial begin
    rst_n       = 1'b0;
    imem_data   = '0;
    cycle_cnt   = 0;
    err_reset   = 0;
    err_flow    = 0;
    err_data    = 0;
    err_timing  = 0;
    err_a0      = 0;
    err_timeout = 0;
    model_pc    = RESET_PC;
    model_done  = 1'b0;
    last_taken  = 1'b0;
    last_target = '0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    void'($urandom(32'h3179));
    build_program();
    imem_data = fetch_word(RESET_PC);

    // one pass per falling edge: sample, then drive
    while (!model_done && cycle_cnt < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycle_cnt++;
      if (cycle_cnt == RESET_CYCLES) begin
        rst_n = 1'b1;
      end
      check_reset();
      if (rst_n && commit.valid) begin
        check_commit();
      end
      check_a0();
      drive_imem();
    end

    if (!model_done) begin
      err_timeout = 1;
      $display("timeout: program not retired within %0d cycles", TIMEOUT_CYCLES);
    end

    $display("errors: reset=%0d flow=%0d data=%0d timing=%0d a0=%0d timeout=%0d",
             err_reset, err_flow, err_data, err_timing, err_a0, err_timeout);
    if (err_reset + err_flow + err_data + err_timing + err_a0 + err_timeout == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk_o
);

  // 100 ns period
  localparam int HALF_PERIOD = 50;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: design/core_top.sv
`timescale 1ns/1ns
`default_nettype none

module core_top
  import core_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  output xlen_t   imem_addr_o,
  input  instr_u  imem_data_i,
  output commit_t commit_o,
  output xlen_t   reg_a0_o
);

  // stage to stage records
  if_id_t    if_id;
  id_ex_t    id_ex;
  ex_wb_t    ex_wb;
  ex_wb_t    wb_q;
  redirect_t redirect;

  // register write port, driven from writeback
  logic      rf_wr_en;
  reg_idx_t  rf_wr_idx;
  xlen_t     rf_wr_data;

  fetch_unit u_fetch_unit (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .redirect_i  (redirect),
    .imem_addr_o (imem_addr_o),
    .imem_data_i (imem_data_i),
    .if_id_o     (if_id)
  );

  decode_stage u_decode_stage (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .if_id_i      (if_id),
    .redirect_i   (redirect),
    .rf_wr_en_i   (rf_wr_en),
    .rf_wr_idx_i  (rf_wr_idx),
    .rf_wr_data_i (rf_wr_data),
    .id_ex_o      (id_ex),
    .reg_a0_o     (reg_a0_o)
  );

  // execute is pure logic, no clock
  exec_stage u_exec_stage (
    .id_ex_i    (id_ex),
    .wb_fwd_i   (wb_q),
    .ex_wb_o    (ex_wb),
    .redirect_o (redirect)
  );

  writeback_stage u_writeback_stage (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ex_wb_i      (ex_wb),
    .wb_o         (wb_q),
    .rf_wr_en_o   (rf_wr_en),
    .rf_wr_idx_o  (rf_wr_idx),
    .rf_wr_data_o (rf_wr_data),
    .commit_o     (commit_o)
  );

endmodule

`default_nettype wire

// File: design/writeback_stage.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_stage
  import core_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  ex_wb_t   ex_wb_i,
  output ex_wb_t   wb_o,
  output logic     rf_wr_en_o,
  output reg_idx_t rf_wr_idx_o,
  output xlen_t    rf_wr_data_o,
  output commit_t  commit_o
);

  ex_wb_t wb_q;

  // EX/WB register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_q.valid <= 1'b0;
    end else begin
      wb_q <= ex_wb_i;
    end
  end

  // also the forwarding source for execute
  assign wb_o = wb_q;

  // regfile write, x0 filtered inside the regfile
  assign rf_wr_en_o   = wb_q.valid & wb_q.wb_en;
  assign rf_wr_idx_o  = wb_q.rd_idx;
  assign rf_wr_data_o = wb_q.result;

  // commit record straight from the register
  assign commit_o.valid  = wb_q.valid;
  assign commit_o.pc     = wb_q.pc;
  assign commit_o.instr  = wb_q.instr;
  assign commit_o.rd_idx = wb_q.rd_idx;
  assign commit_o.wb_en  = wb_q.wb_en;
  assign commit_o.data   = wb_q.result;

endmodule

`default_nettype wire

// File: design/exec_stage.sv
`timescale 1ns/1ns
`default_nettype none

module exec_stage
  import core_pkg::*;
(
  input  id_ex_t    id_ex_i,
  input  ex_wb_t    wb_fwd_i,
  output ex_wb_t    ex_wb_o,
  output redirect_t redirect_o
);

  logic  fwd_ok;
  xlen_t op_a;
  xlen_t rs2_fwd;
  xlen_t op_b;
  xlen_t alu_res;
  logic  br_eq;
  logic  br_taken;

  // writeback holds the only result not yet in the regfile
  assign fwd_ok = wb_fwd_i.valid & wb_fwd_i.wb_en & (wb_fwd_i.rd_idx != '0);

  assign op_a = (fwd_ok && wb_fwd_i.rd_idx == id_ex_i.rs1_idx) ?
                wb_fwd_i.result : id_ex_i.rs1_val;
  assign rs2_fwd = (fwd_ok && wb_fwd_i.rd_idx == id_ex_i.rs2_idx) ?
                   wb_fwd_i.result : id_ex_i.rs2_val;

  // imm forms and lui take the immediate
  assign op_b = id_ex_i.use_imm ? id_ex_i.imm : rs2_fwd;

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_OR:     alu_res = op_a | op_b;
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = op_a + op_b;
    endcase
  end

  // beq / bne compare forwarded register values
  assign br_eq    = (op_a == rs2_fwd);
  assign br_taken = id_ex_i.valid & id_ex_i.is_branch & (br_eq ^ id_ex_i.branch_ne);

  // combinational redirect, same cycle as the branch
  assign redirect_o.valid  = br_taken;
  assign redirect_o.target = id_ex_i.pc + id_ex_i.imm;

  // branch itself still retires, with wb_en low
  assign ex_wb_o.valid  = id_ex_i.valid;
  assign ex_wb_o.pc     = id_ex_i.pc;
  assign ex_wb_o.instr  = id_ex_i.instr;
  assign ex_wb_o.rd_idx = id_ex_i.rd_idx;
  assign ex_wb_o.wb_en  = id_ex_i.wb_en;
  assign ex_wb_o.result = alu_res;

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit
  import core_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  redirect_t redirect_i,
  output xlen_t     imem_addr_o,
  input  instr_u    imem_data_i,
  output if_id_t    if_id_o
);

  xlen_t  pc_q;
  xlen_t  pc_next;
  if_id_t if_id_q;

  // taken branch wins over sequential pc
  assign pc_next = redirect_i.valid ? redirect_i.target : pc_q + xlen_t'(4);

  // imem answers in the same cycle
  assign imem_addr_o = pc_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  // IF/ID register
  // slot fetched during a redirect is wrong path
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      if_id_q.valid <= 1'b0;
    end else begin
      if_id_q.valid <= ~redirect_i.valid;
      if_id_q.pc    <= pc_q;
      if_id_q.instr <= imem_data_i;
    end
  end

  assign if_id_o = if_id_q;

endmodule

`default_nettype wire

// File: decode/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage
  import core_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  if_id_t    if_id_i,
  input  redirect_t redirect_i,
  input  logic      rf_wr_en_i,
  input  reg_idx_t  rf_wr_idx_i,
  input  xlen_t     rf_wr_data_i,
  output id_ex_t    id_ex_o,
  output xlen_t     reg_a0_o
);

  instr_u  instr;
  xlen_t   rs1_val;
  xlen_t   rs2_val;
  xlen_t   imm_i_type;
  xlen_t   imm_b_type;
  xlen_t   imm_u_type;
  alu_op_e f3_alu_op;
  logic    f3_known;
  logic    known;
  id_ex_t  id_ex_d;
  id_ex_t  id_ex_q;

  assign instr = if_id_i.instr;

  // operands, bypassed from the write port inside
  reg_file u_reg_file (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .rs1_idx_i (instr.r_view.rs1),
    .rs2_idx_i (instr.r_view.rs2),
    .rs1_val_o (rs1_val),
    .rs2_val_o (rs2_val),
    .wr_en_i   (rf_wr_en_i),
    .wr_idx_i  (rf_wr_idx_i),
    .wr_data_i (rf_wr_data_i),
    .a0_o      (reg_a0_o)
  );

  // immediates
  assign imm_i_type = {{(XLEN-12){instr.i_view.imm12[11]}}, instr.i_view.imm12};
  // B-type offset is scattered over funct7 and rd
  assign imm_b_type = {{(XLEN-13){instr.r_view.funct7[6]}}, instr.r_view.funct7[6],
                       instr.r_view.rd[0], instr.r_view.funct7[5:0],
                       instr.r_view.rd[4:1], 1'b0};
  assign imm_u_type = {{(XLEN-32){instr.i_view.imm12[11]}}, instr.i_view.imm12,
                       instr.i_view.rs1, instr.i_view.funct3, 12'b0};

  // funct3 map, shared by reg and imm forms
  always_comb begin
    f3_alu_op = ALU_ADD;
    f3_known  = 1'b1;
    case (instr.i_view.funct3)
      F3_ADD_SUB: f3_alu_op = ALU_ADD;
      F3_XOR:     f3_alu_op = ALU_XOR;
      F3_OR:      f3_alu_op = ALU_OR;
      F3_AND:     f3_alu_op = ALU_AND;
      default:    f3_known  = 1'b0;
    endcase
  end

  always_comb begin
    id_ex_d         = '0;
    known           = 1'b1;
    id_ex_d.pc      = if_id_i.pc;
    id_ex_d.instr   = instr;
    id_ex_d.rs1_idx = instr.r_view.rs1;
    id_ex_d.rs2_idx = instr.r_view.rs2;
    id_ex_d.rd_idx  = instr.r_view.rd;
    id_ex_d.rs1_val = rs1_val;
    id_ex_d.rs2_val = rs2_val;
    id_ex_d.imm     = imm_i_type;
    id_ex_d.alu_op  = f3_alu_op;
    case (instr.r_view.opcode)
      OPC_OP: begin
        id_ex_d.wb_en = 1'b1;
        known         = f3_known;
        if (instr.r_view.funct3 == F3_ADD_SUB && instr.r_view.funct7 == F7_SUB) begin
          id_ex_d.alu_op = ALU_SUB;
        end
      end
      OPC_OP_IMM: begin
        id_ex_d.wb_en   = 1'b1;
        id_ex_d.use_imm = 1'b1;
        known           = f3_known;
      end
      OPC_LUI: begin
        id_ex_d.wb_en   = 1'b1;
        id_ex_d.use_imm = 1'b1;
        id_ex_d.imm     = imm_u_type;
        id_ex_d.alu_op  = ALU_PASS_B;
      end
      OPC_BRANCH: begin
        id_ex_d.is_branch = 1'b1;
        id_ex_d.imm       = imm_b_type;
        id_ex_d.branch_ne = (instr.r_view.funct3 == F3_BNE);
        known = (instr.r_view.funct3 == F3_BEQ) || (instr.r_view.funct3 == F3_BNE);
      end
      default: known = 1'b0;
    endcase
    // unknown encodings leave as bubbles
    id_ex_d.wb_en = id_ex_d.wb_en & known;
    id_ex_d.valid = if_id_i.valid & known & ~redirect_i.valid;
  end

  // ID/EX register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex_q.valid <= 1'b0;
    end else begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

// File: decode/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file
  import core_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  reg_idx_t rs1_idx_i,
  input  reg_idx_t rs2_idx_i,
  output xlen_t    rs1_val_o,
  output xlen_t    rs2_val_o,
  input  logic     wr_en_i,
  input  reg_idx_t wr_idx_i,
  input  xlen_t    wr_data_i,
  output xlen_t    a0_o
);

  xlen_t regs [2**REG_ADDR_W];

  // same-cycle write shows through to the reader
  function automatic xlen_t read_port(input reg_idx_t idx);
    xlen_t val;
    val = regs[idx];
    if (wr_en_i && wr_idx_i == idx && idx != '0) begin
      val = wr_data_i;
    end
    return val;
  endfunction

  // x0 is never written so stays at reset zero
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 2**REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && wr_idx_i != '0) begin
      regs[wr_idx_i] <= wr_data_i;
    end
  end

  assign rs1_val_o = read_port(rs1_idx_i);
  assign rs2_val_o = read_port(rs2_idx_i);
  // a0 tracks the instruction now on commit
  assign a0_o      = read_port(reg_idx_t'(10));

endmodule

`default_nettype wire

// File: common/core_pkg.sv
`default_nettype none

package core_pkg;

  // datapath and instruction widths
  localparam int XLEN       = 64;
  localparam int INST_LEN   = 32;
  localparam int REG_ADDR_W = 5;

  localparam logic [XLEN-1:0] RESET_PC = '0;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [REG_ADDR_W-1:0] reg_idx_t;

  // ALU_PASS_B feeds the immediate straight through for lui
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_PASS_B = 3'd5
  } alu_op_e;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct3 / funct7 codes
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  // one instruction word, seen as R-type or I-type fields
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      logic [6:0] opcode;
    } r_view;
    struct packed {
      logic [11:0] imm12;
      reg_idx_t    rs1;
      logic [2:0]  funct3;
      reg_idx_t    rd;
      logic [6:0]  opcode;
    } i_view;
  } instr_u;

  typedef struct packed {
    logic   valid;
    xlen_t  pc;
    instr_u instr;
  } if_id_t;

  typedef struct packed {
    logic     valid;
    xlen_t    pc;
    instr_u   instr;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    reg_idx_t rd_idx;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    xlen_t    imm;
    alu_op_e  alu_op;
    logic     use_imm;
    logic     wb_en;
    logic     is_branch;
    logic     branch_ne;
  } id_ex_t;

  typedef struct packed {
    logic     valid;
    xlen_t    pc;
    instr_u   instr;
    reg_idx_t rd_idx;
    logic     wb_en;
    xlen_t    result;
  } ex_wb_t;

  typedef struct packed {
    logic  valid;
    xlen_t target;
  } redirect_t;

  // retired instruction record, difftest style
  typedef struct packed {
    logic     valid;
    xlen_t    pc;
    instr_u   instr;
    reg_idx_t rd_idx;
    logic     wb_en;
    xlen_t    data;
  } commit_t;

endpackage

`default_nettype wire
